//--- include/fetch_defs.svh
////////////////////////////////////////////////////////////
// Fetch unit constants
// Strand count, queue depth, cache size and the multiply
// opcodes that mark long-latency arithmetic
////////////////////////////////////////////////////////////

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Hardware strands sharing the fetch unit
`define FETCH_STRANDS 4
// Entries per strand instruction queue
`define FETCH_QUEUE_DEPTH 2
// One word per line, indexed by PC bits 5:2
`define FETCH_CACHE_LINES 16

// Integer multiply, format A and format B
`define FETCH_OP_IMUL_A 6'h07
`define FETCH_OP_IMUL_B 5'h07

`endif

//--- verilog/fetch_pkg.sv
////////////////////////////////////////////////////////////
// Fetch unit types
// Instruction words, addresses, strand numbers and the
// queue entry handed to the strand select stage
////////////////////////////////////////////////////////////

`include "fetch_defs.svh"

package fetch_pkg;

	// Instruction word, memory or decoded byte order
	typedef logic [31:0] word_t;

	// Byte address
	typedef logic [31:0] pc_t;

	typedef logic [$clog2(`FETCH_STRANDS)-1:0] strand_idx_t;

	// 66 bits, one instruction queue slot
	typedef struct packed
	{
		pc_t next_pc;
		word_t instruction;
		logic branch_predicted;
		logic long_latency;
	} fetch_entry_t;

endpackage

//--- verilog/lru_arbiter.sv
////////////////////////////////////////////////////////////
// Four-way least recently granted arbiter
// One-hot grant per cycle, priority moves past the winner
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module lru_arbiter
(
	input  logic clk,
	input  logic reset,
	input  logic [3:0] request_i,
	input  logic update_lru_i,
	output logic [3:0] grant_oh_o
);

	// Requester with first claim on the next grant
	logic [1:0] priority_q;
	logic [1:0] grant_idx;
	logic [1:0] candidate;

	always_comb
	begin
		grant_idx = priority_q;
		// Walk from the weakest position up so the strongest match wins
		for (int i = 3; i >= 0; i--)
		begin
			candidate = priority_q + 2'(i);
			if (request_i[candidate])
				grant_idx = candidate;
		end
		grant_oh_o = (request_i != 4'b0000) ? (4'b0001 << grant_idx) : 4'b0000;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			priority_q <= 2'd0;
		else if (update_lru_i && request_i != 4'b0000)
			priority_q <= grant_idx + 2'd1;
	end

endmodule

//--- verilog/sync_fifo.sv
////////////////////////////////////////////////////////////
// Small synchronous queue
// Circular buffer of any payload type with flush and
// full, almost-full and empty flags
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module sync_fifo
#(
	parameter type payload_t = fetch_pkg::fetch_entry_t,
	parameter int DEPTH = 2
)
(
	input  logic clk,
	input  logic reset,
	input  logic flush_i,
	input  logic enqueue_i,
	input  payload_t value_i,
	input  logic dequeue_i,
	output payload_t value_o,
	output logic full_o,
	output logic almost_full_o,
	output logic empty_o
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int COUNT_W = $clog2(DEPTH + 1);

	payload_t storage [DEPTH];
	logic [PTR_W-1:0] read_ptr_q;
	logic [PTR_W-1:0] write_ptr_q;
	logic [COUNT_W-1:0] count_q;
	logic do_enqueue;
	logic do_dequeue;

	function automatic logic [PTR_W-1:0] advance(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	assign do_enqueue = enqueue_i && !full_o;
	assign do_dequeue = dequeue_i && !empty_o;

	assign full_o = count_q == COUNT_W'(DEPTH);
	assign almost_full_o = count_q == COUNT_W'(DEPTH - 1);
	assign empty_o = count_q == '0;
	// Oldest entry
	assign value_o = storage[read_ptr_q];

	always_ff @(posedge clk)
	begin
		if (do_enqueue)
			storage[write_ptr_q] <= value_i;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			read_ptr_q <= '0;
			write_ptr_q <= '0;
			count_q <= '0;
		end
		else if (flush_i)
		begin
			// Drops everything, including a write in this cycle
			read_ptr_q <= '0;
			write_ptr_q <= '0;
			count_q <= '0;
		end
		else
		begin
			if (do_enqueue)
				write_ptr_q <= advance(write_ptr_q);
			if (do_dequeue)
				read_ptr_q <= advance(read_ptr_q);
			if (do_enqueue && !do_dequeue)
				count_q <= count_q + 1'b1;
			else if (do_dequeue && !do_enqueue)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

//--- verilog/fetch_predecoder.sv
////////////////////////////////////////////////////////////
// Fetch pre-decoder
// Byte-swaps the fetched word, predicts branches statically
// and flags long-latency arithmetic
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_predecoder
(
	input  fetch_pkg::word_t raw_word_i,
	input  fetch_pkg::pc_t pc_i,
	output fetch_pkg::fetch_entry_t entry_o,
	output fetch_pkg::pc_t target_pc_o
);
	import fetch_pkg::*;

	word_t swapped;
	pc_t sequential_pc;
	pc_t branch_offset;
	logic [2:0] branch_kind;
	logic is_branch;
	logic is_conditional;
	logic predicted_taken;
	logic long_latency;

	// First memory byte lands in bits 7:0
	assign swapped = {raw_word_i[7:0], raw_word_i[15:8], raw_word_i[23:16], raw_word_i[31:24]};
	assign sequential_pc = pc_i + 32'd4;

	assign is_branch = swapped[31:28] == 4'b1111;
	assign branch_kind = swapped[27:25];
	assign branch_offset = {{12{swapped[24]}}, swapped[24:5]};

	always_comb
	begin
		case (branch_kind)
			3'b000, 3'b001, 3'b010, 3'b101: is_conditional = 1'b1;
			default: is_conditional = 1'b0;
		endcase
	end

	// Always and call are taken, conditionals only when backward
	assign predicted_taken = is_branch && (branch_kind == 3'b011 || branch_kind == 3'b100
		|| (is_conditional && branch_offset[31]));

	always_comb
	begin
		if (swapped[31:29] == 3'b110)
			long_latency = swapped[28] || swapped[28:23] == `FETCH_OP_IMUL_A;
		else if (!swapped[31])
			long_latency = swapped[30:26] == `FETCH_OP_IMUL_B;
		else
			long_latency = 1'b0;
	end

	always_comb
	begin
		entry_o.next_pc = sequential_pc;
		entry_o.instruction = swapped;
		entry_o.branch_predicted = predicted_taken;
		entry_o.long_latency = long_latency;
	end

	assign target_pc_o = predicted_taken ? sequential_pc + branch_offset : sequential_pc;

endmodule

//--- verilog/instruction_cache.sv
////////////////////////////////////////////////////////////
// Instruction cache
// Direct mapped, one word per line, one outstanding fill
// that releases every strand which missed on that line
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fetch_defs.svh"

module instruction_cache
(
	input  logic clk,
	input  logic reset,
	input  fetch_pkg::pc_t addr_i,
	input  logic request_i,
	input  fetch_pkg::strand_idx_t req_strand_i,
	output logic hit_o,
	output fetch_pkg::word_t data_o,
	output logic load_collision_o,
	output logic [3:0] load_complete_strands_o,
	output logic mem_read_o,
	output fetch_pkg::pc_t mem_addr_o,
	input  fetch_pkg::word_t mem_data_i,
	input  logic mem_valid_i
);
	import fetch_pkg::*;

	localparam int INDEX_W = $clog2(`FETCH_CACHE_LINES);
	localparam int TAG_W = 32 - INDEX_W - 2;

	word_t data_mem [`FETCH_CACHE_LINES];
	logic [TAG_W-1:0] tag_mem [`FETCH_CACHE_LINES];
	logic [`FETCH_CACHE_LINES-1:0] valid_q;

	// Fill in progress
	logic fill_pending_q;
	pc_t fill_addr_q;
	logic [`FETCH_STRANDS-1:0] fill_waiting_q;

	logic [INDEX_W-1:0] req_index;
	logic [TAG_W-1:0] req_tag;
	logic [INDEX_W-1:0] fill_index;
	logic [`FETCH_STRANDS-1:0] strand_bit;
	logic [`FETCH_STRANDS-1:0] complete_next;
	logic fill_done;
	logic lookup_hit;
	logic miss;
	logic same_line;
	logic start_fill;
	logic collision;
	logic dropped;

	assign req_index = addr_i[INDEX_W+1:2];
	assign req_tag = addr_i[31:INDEX_W+2];
	assign fill_index = fill_addr_q[INDEX_W+1:2];
	assign strand_bit = `FETCH_STRANDS'(1) << req_strand_i;
	assign fill_done = fill_pending_q && mem_valid_i;

	assign lookup_hit = request_i && valid_q[req_index] && tag_mem[req_index] == req_tag;
	assign miss = request_i && !lookup_hit;
	assign same_line = fill_pending_q && fill_addr_q[31:2] == addr_i[31:2];
	assign start_fill = miss && !fill_pending_q;
	assign collision = miss && same_line;
	// Fill busy on another line, strand retries later
	assign dropped = miss && fill_pending_q && !same_line;

	assign mem_read_o = fill_pending_q;
	assign mem_addr_o = fill_addr_q;

	// A dropped miss is released straight away so the strand never waits on it
	always_comb
	begin
		complete_next = strand_bit & {`FETCH_STRANDS{dropped}};
		if (fill_done)
			complete_next = complete_next | fill_waiting_q
				| (strand_bit & {`FETCH_STRANDS{collision}});
	end

	always_ff @(posedge clk)
	begin
		if (fill_done)
		begin
			data_mem[fill_index] <= mem_data_i;
			tag_mem[fill_index] <= fill_addr_q[31:INDEX_W+2];
		end
		if (start_fill)
			fill_addr_q <= {addr_i[31:2], 2'b00};
		data_o <= data_mem[req_index];
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			fill_pending_q <= 1'b0;
			fill_waiting_q <= '0;
			hit_o <= 1'b0;
			load_collision_o <= 1'b0;
			load_complete_strands_o <= '0;
		end
		else
		begin
			hit_o <= lookup_hit;
			load_collision_o <= collision;
			load_complete_strands_o <= complete_next;
			if (fill_done)
			begin
				valid_q[fill_index] <= 1'b1;
				fill_pending_q <= 1'b0;
				fill_waiting_q <= '0;
			end
			else if (start_fill)
			begin
				fill_pending_q <= 1'b1;
				fill_waiting_q <= strand_bit;
			end
			else if (collision)
				fill_waiting_q <= fill_waiting_q | strand_bit;
		end
	end

endmodule

//--- verilog/instruction_fetch_stage.sv
////////////////////////////////////////////////////////////
// Instruction fetch stage
// Keeps one PC and one instruction queue per strand, picks
// a strand for the cache each cycle and follows predictions
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fetch_defs.svh"

module instruction_fetch_stage
(
	input  logic clk,
	input  logic reset,

	// Cache request and response
	output fetch_pkg::pc_t icache_addr_o,
	output logic icache_request_o,
	output fetch_pkg::strand_idx_t icache_req_strand_o,
	input  logic icache_hit_i,
	input  fetch_pkg::word_t icache_data_i,
	input  logic icache_load_collision_i,
	input  logic [`FETCH_STRANDS-1:0] icache_load_complete_strands_i,

	// Strand select side
	output fetch_pkg::word_t instruction_o [`FETCH_STRANDS],
	output logic instruction_valid_o [`FETCH_STRANDS],
	output fetch_pkg::pc_t pc_o [`FETCH_STRANDS],
	output logic branch_predicted_o [`FETCH_STRANDS],
	output logic long_latency_o [`FETCH_STRANDS],
	input  logic instruction_req_i [`FETCH_STRANDS],
	input  logic rollback_i [`FETCH_STRANDS],
	input  fetch_pkg::pc_t rollback_pc_i [`FETCH_STRANDS]
);
	import fetch_pkg::*;

	localparam int NUM_STRANDS = `FETCH_STRANDS;

	pc_t pc_q [NUM_STRANDS];
	pc_t pc_nxt [NUM_STRANDS];
	fetch_entry_t queue_head [NUM_STRANDS];

	// Strand whose response arrives this cycle
	logic [NUM_STRANDS-1:0] request_oh_q;
	logic [NUM_STRANDS-1:0] grant_oh;
	logic [NUM_STRANDS-1:0] wait_q;
	logic [NUM_STRANDS-1:0] wait_nxt;
	logic [NUM_STRANDS-1:0] miss_oh;
	logic [NUM_STRANDS-1:0] enqueue;
	logic [NUM_STRANDS-1:0] fetch_ready;
	logic [NUM_STRANDS-1:0] full;
	logic [NUM_STRANDS-1:0] almost_full;
	logic [NUM_STRANDS-1:0] empty;
	strand_idx_t last_strand;
	fetch_entry_t entry;
	pc_t target_pc;

	function automatic strand_idx_t oh_to_idx(input logic [NUM_STRANDS-1:0] oh);
		strand_idx_t idx;
		idx = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (oh[i])
				idx = strand_idx_t'(i);
		end
		return idx;
	endfunction

	assign enqueue = request_oh_q & {NUM_STRANDS{icache_hit_i}};

	// A collision waits on the fill already under way like a plain miss
	assign miss_oh = request_oh_q & {NUM_STRANDS{!icache_hit_i || icache_load_collision_i}};
	assign wait_nxt = (wait_q | miss_oh) & ~icache_load_complete_strands_i;

	// Leave room for the entry that lands this cycle
	assign fetch_ready = ~full & ~(almost_full & enqueue);

	lru_arbiter u_arbiter
	(
		.clk(clk),
		.reset(reset),
		.request_i(fetch_ready & ~wait_nxt),
		.update_lru_i(icache_request_o),
		.grant_oh_o(grant_oh)
	);

	assign icache_request_o = grant_oh != '0;
	assign icache_req_strand_o = oh_to_idx(grant_oh);
	// Next PC so a strand can fetch back to back
	assign icache_addr_o = pc_nxt[icache_req_strand_o];
	assign last_strand = oh_to_idx(request_oh_q);

	fetch_predecoder u_predecoder
	(
		.raw_word_i(icache_data_i),
		.pc_i(pc_q[last_strand]),
		.entry_o(entry),
		.target_pc_o(target_pc)
	);

	always_comb
	begin
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			if (rollback_i[i])
				pc_nxt[i] = rollback_pc_i[i];
			else if (enqueue[i])
				pc_nxt[i] = target_pc;
			else
				pc_nxt[i] = pc_q[i];
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_STRANDS; i++)
				pc_q[i] <= '0;
			request_oh_q <= '0;
			wait_q <= '0;
		end
		else
		begin
			pc_q <= pc_nxt;
			request_oh_q <= grant_oh;
			wait_q <= wait_nxt;
		end
	end

	for (genvar g = 0; g < NUM_STRANDS; g++)
	begin : g_strand
		sync_fifo
		#(
			.payload_t(fetch_entry_t),
			.DEPTH(`FETCH_QUEUE_DEPTH)
		)
		u_queue
		(
			.clk(clk),
			.reset(reset),
			.flush_i(rollback_i[g]),
			.enqueue_i(enqueue[g]),
			.value_i(entry),
			.dequeue_i(instruction_req_i[g] && !empty[g]),
			.value_o(queue_head[g]),
			.full_o(full[g]),
			.almost_full_o(almost_full[g]),
			.empty_o(empty[g])
		);

		assign instruction_o[g] = queue_head[g].instruction;
		assign pc_o[g] = queue_head[g].next_pc;
		assign branch_predicted_o[g] = queue_head[g].branch_predicted;
		assign long_latency_o[g] = queue_head[g].long_latency;
		assign instruction_valid_o[g] = !empty[g];
	end

endmodule

//--- verilog/fetch_unit_top.sv
////////////////////////////////////////////////////////////
// Fetch unit top level
// Fetch stage plus instruction cache, with the strand
// ports and the external memory port
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_unit_top
(
	input  logic clk,
	input  logic reset,

	output fetch_pkg::word_t instruction_o [`FETCH_STRANDS],
	output logic instruction_valid_o [`FETCH_STRANDS],
	output fetch_pkg::pc_t pc_o [`FETCH_STRANDS],
	output logic branch_predicted_o [`FETCH_STRANDS],
	output logic long_latency_o [`FETCH_STRANDS],
	input  logic instruction_req_i [`FETCH_STRANDS],
	input  logic rollback_i [`FETCH_STRANDS],
	input  fetch_pkg::pc_t rollback_pc_i [`FETCH_STRANDS],

	// External memory
	output logic mem_read_o,
	output fetch_pkg::pc_t mem_addr_o,
	input  fetch_pkg::word_t mem_data_i,
	input  logic mem_valid_i
);
	import fetch_pkg::*;

	pc_t icache_addr;
	logic icache_request;
	strand_idx_t icache_req_strand;
	logic icache_hit;
	word_t icache_data;
	logic icache_load_collision;
	logic [`FETCH_STRANDS-1:0] icache_load_complete_strands;

	instruction_fetch_stage u_fetch_stage
	(
		.clk(clk),
		.reset(reset),
		.icache_addr_o(icache_addr),
		.icache_request_o(icache_request),
		.icache_req_strand_o(icache_req_strand),
		.icache_hit_i(icache_hit),
		.icache_data_i(icache_data),
		.icache_load_collision_i(icache_load_collision),
		.icache_load_complete_strands_i(icache_load_complete_strands),
		.instruction_o(instruction_o),
		.instruction_valid_o(instruction_valid_o),
		.pc_o(pc_o),
		.branch_predicted_o(branch_predicted_o),
		.long_latency_o(long_latency_o),
		.instruction_req_i(instruction_req_i),
		.rollback_i(rollback_i),
		.rollback_pc_i(rollback_pc_i)
	);

	instruction_cache u_icache
	(
		.clk(clk),
		.reset(reset),
		.addr_i(icache_addr),
		.request_i(icache_request),
		.req_strand_i(icache_req_strand),
		.hit_o(icache_hit),
		.data_o(icache_data),
		.load_collision_o(icache_load_collision),
		.load_complete_strands_o(icache_load_complete_strands),
		.mem_read_o(mem_read_o),
		.mem_addr_o(mem_addr_o),
		.mem_data_i(mem_data_i),
		.mem_valid_i(mem_valid_i)
	);

endmodule

//--- tests/fetch_unit_asserts.sv
////////////////////////////////////////////////////////////
// Fetch unit assertions
// Memory read hold, hit and collision exclusion, and
// rollback target rules
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module fetch_unit_asserts
(
	input  logic clk,
	input  logic reset,
	input  logic mem_read_i,
	input  logic mem_valid_i,
	input  logic hit_i,
	input  logic collision_i,
	input  logic [3:0] rollback_valid_i,
	input  logic [3:0] rollback_pc_zero_i
);

	// A fill keeps its read up until the memory answers
	read_held: assert property (@(posedge clk) disable iff (reset)
		mem_read_i && !mem_valid_i |=> mem_read_i)
		else $error("memory read dropped before the memory answered");

	hit_or_collision: assert property (@(posedge clk) disable iff (reset)
		!(hit_i && collision_i))
		else $error("cache reported a hit and a load collision together");

	no_rollback_to_zero: assert property (@(posedge clk) disable iff (reset)
		(rollback_valid_i & rollback_pc_zero_i) == 4'b0000)
		else $error("rollback requested to address zero");

endmodule

// Cache side, rollback inputs unused here
bind instruction_cache fetch_unit_asserts u_cache_asserts
(
	.clk(clk),
	.reset(reset),
	.mem_read_i(mem_read_o),
	.mem_valid_i(mem_valid_i),
	.hit_i(hit_o),
	.collision_i(load_collision_o),
	.rollback_valid_i(4'b0000),
	.rollback_pc_zero_i(4'b0000)
);

bind instruction_fetch_stage fetch_unit_asserts u_stage_asserts
(
	.clk(clk),
	.reset(reset),
	.mem_read_i(1'b0),
	.mem_valid_i(1'b0),
	.hit_i(1'b0),
	.collision_i(1'b0),
	.rollback_valid_i({rollback_i[3], rollback_i[2], rollback_i[1], rollback_i[0]}),
	.rollback_pc_zero_i({rollback_pc_i[3] == 32'd0, rollback_pc_i[2] == 32'd0,
		rollback_pc_i[1] == 32'd0, rollback_pc_i[0] == 32'd0})
);

//--- tests/fetch_unit_tb.sv
////////////////////////////////////////////////////////////
// Fetch unit testbench
// Directed tests against a memory model on the fill port
////////////////////////////////////////////////////////////
`timescale 1ns/10ps
`include "fetch_defs.svh"

module fetch_unit_tb;
	import fetch_pkg::*;

	localparam int NUM_STRANDS = `FETCH_STRANDS;
	localparam int NUM_TESTS = 6;
	localparam int CYCLES_PER_TEST = 200;
	localparam int MEM_LATENCY = 3;
	localparam int FILL_PAUSE = 20;

	logic clk;
	logic reset;
	word_t instruction [NUM_STRANDS];
	logic instruction_valid [NUM_STRANDS];
	pc_t pc [NUM_STRANDS];
	logic branch_predicted [NUM_STRANDS];
	logic long_latency [NUM_STRANDS];
	logic instruction_req [NUM_STRANDS];
	logic rollback [NUM_STRANDS];
	pc_t rollback_pc [NUM_STRANDS];
	logic mem_read;
	pc_t mem_addr;
	word_t mem_data;
	logic mem_valid;

	// Words kept in memory byte order
	word_t memory [pc_t];
	pc_t read_addr;
	int mem_reads;
	int error_count;
	int errors_before;
	int tests_run;
	int failed_tests;
	int unsigned lcg_state;
	string test_name;

	fetch_unit_top u_fetch_unit_top
	(
		.clk(clk),
		.reset(reset),
		.instruction_o(instruction),
		.instruction_valid_o(instruction_valid),
		.pc_o(pc),
		.branch_predicted_o(branch_predicted),
		.long_latency_o(long_latency),
		.instruction_req_i(instruction_req),
		.rollback_i(rollback),
		.rollback_pc_i(rollback_pc),
		.mem_read_o(mem_read),
		.mem_addr_o(mem_addr),
		.mem_data_i(mem_data),
		.mem_valid_i(mem_valid)
	);

	always
	begin
		#5 clk = ~clk;
	end

	// Memory answers each fill a fixed number of cycles after the read rises
	always
	begin
		@(negedge clk);
		if (mem_read === 1'b1)
		begin
			mem_reads++;
			read_addr = mem_addr;
			repeat (MEM_LATENCY - 1) @(negedge clk);
			// The address must hold for the whole read
			check_pc("memory address", read_addr, mem_addr);
			mem_data = read_memory(read_addr);
			mem_valid = 1'b1;
			@(negedge clk);
			mem_valid = 1'b0;
		end
	end

	initial
	begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
		$display("Watchdog expired: the tests did not finish within %0d cycles",
			NUM_TESTS * CYCLES_PER_TEST);
		$display("CHECKS FAILED");
		$finish;
	end

	function automatic word_t next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Format B, never a branch and never a multiply
	function automatic word_t filler_word();
		word_t w;
		w = next_random();
		w[31] = 1'b0;
		if (w[30:26] == `FETCH_OP_IMUL_B)
			w[26] = ~w[26];
		return w;
	endfunction

	function automatic word_t branch_word(input logic [2:0] kind, input pc_t offset);
		return {4'b1111, kind, offset[19:0], 5'b00000};
	endfunction

	// First memory byte is bits 7:0 of the decoded word
	function automatic word_t swap_bytes(input word_t w);
		return {w[7:0], w[15:8], w[23:16], w[31:24]};
	endfunction

	// Plain format B word for addresses that no test wrote
	function automatic word_t fill_pattern(input pc_t addr);
		return {6'b000000, addr[27:2] ^ {22'd0, addr[31:28]}};
	endfunction

	function automatic word_t read_memory(input pc_t addr);
		if (memory.exists(addr))
			return memory[addr];
		return swap_bytes(fill_pattern(addr));
	endfunction

	function automatic logic predict_taken(input word_t w);
		if (w[31:28] != 4'b1111)
			return 1'b0;
		case (w[27:25])
			3'b011, 3'b100: return 1'b1;
			3'b000, 3'b001, 3'b010, 3'b101: return w[24];
			default: return 1'b0;
		endcase
	endfunction

	function automatic pc_t predicted_target(input pc_t fetch_pc, input word_t w);
		pc_t offset;
		offset = {{12{w[24]}}, w[24:5]};
		if (predict_taken(w))
			return fetch_pc + 32'd4 + offset;
		return fetch_pc + 32'd4;
	endfunction

	function automatic logic expect_long_latency(input word_t w);
		if (w[31:29] == 3'b110)
			return w[28] || (w[28:23] == `FETCH_OP_IMUL_A);
		return !w[31] && (w[30:26] == `FETCH_OP_IMUL_B);
	endfunction

	task automatic store_word(input pc_t addr, input word_t decoded);
		memory[addr] = swap_bytes(decoded);
	endtask

	task automatic check_word(input string what, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_pc(input string what, input pc_t expected, input pc_t actual);
		if (expected !== actual)
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h",
				test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_flag(input string what, input bit expected, input bit actual);
		if (expected != actual)
		begin
			$display("CHECK FAILED %s %s: expected %0b, actual %0b",
				test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_count(input string what, input int expected, input int actual);
		if (expected != actual)
		begin
			$display("CHECK FAILED %s %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			error_count++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_before = error_count;
	endtask

	task automatic finish_test();
		tests_run++;
		if (error_count == errors_before)
			$display("[PASS] %s", test_name);
		else
		begin
			failed_tests++;
			$display("[FAIL] %s with %0d mismatches", test_name, error_count - errors_before);
		end
	endtask

	task automatic wait_valid(input int strand);
		@(negedge clk);
		while (instruction_valid[strand] !== 1'b1)
			@(negedge clk);
	endtask

	// Samples the head entry, then dequeues it on the next edge
	task automatic pop_entry(input int strand, output fetch_entry_t entry);
		wait_valid(strand);
		entry.instruction = instruction[strand];
		entry.next_pc = pc[strand];
		entry.branch_predicted = branch_predicted[strand];
		entry.long_latency = long_latency[strand];
		instruction_req[strand] = 1'b1;
		@(negedge clk);
		instruction_req[strand] = 1'b0;
	endtask

	task automatic expect_next(input int strand, inout pc_t fetch_pc);
		fetch_entry_t entry;
		word_t expected_word;
		pop_entry(strand, entry);
		expected_word = swap_bytes(read_memory(fetch_pc));
		check_word($sformatf("strand %0d instruction", strand), expected_word, entry.instruction);
		check_pc($sformatf("strand %0d pc", strand), fetch_pc + 32'd4, entry.next_pc);
		check_flag($sformatf("strand %0d branch_predicted", strand),
			predict_taken(expected_word), entry.branch_predicted);
		check_flag($sformatf("strand %0d long_latency", strand),
			expect_long_latency(expected_word), entry.long_latency);
		fetch_pc = predicted_target(fetch_pc, expected_word);
	endtask

	task automatic follow_strand(input int strand, input pc_t start_pc, input int count);
		pc_t fetch_pc;
		fetch_pc = start_pc;
		for (int i = 0; i < count; i++)
			expect_next(strand, fetch_pc);
	endtask

	task automatic roll_back(input int strand, input pc_t target);
		@(negedge clk);
		rollback[strand] = 1'b1;
		rollback_pc[strand] = target;
		@(negedge clk);
		rollback[strand] = 1'b0;
	endtask

	task automatic test_sequential_fetch();
		start_test("sequential_fetch");
		for (int i = 0; i < 8; i++)
			store_word(32'h100 + 32'(4 * i), filler_word());
		roll_back(0, 32'h100);
		follow_strand(0, 32'h100, 8);
		finish_test();
	endtask

	// Always, call, backward and forward conditionals in a small loop
	task automatic test_branch_prediction();
		start_test("branch_prediction");
		store_word(32'h400, branch_word(3'b011, 32'h10));
		store_word(32'h410, branch_word(3'b101, 32'h40));
		store_word(32'h414, branch_word(3'b100, 32'h8));
		store_word(32'h420, branch_word(3'b000, -32'd20));
		roll_back(0, 32'h400);
		follow_strand(0, 32'h400, 6);
		finish_test();
	endtask

	task automatic test_long_latency();
		word_t w;
		start_test("long_latency");
		w = next_random();
		w[31:28] = 4'b1101;
		store_word(32'h800, w);
		w = next_random();
		w[31:29] = 3'b110;
		w[28:23] = `FETCH_OP_IMUL_A;
		store_word(32'h804, w);
		w = filler_word();
		w[30:26] = `FETCH_OP_IMUL_B;
		store_word(32'h808, w);
		store_word(32'h80C, filler_word());
		// Format A that is neither flagged form
		w = next_random();
		w[31:28] = 4'b1100;
		w[27:23] = 5'h03;
		store_word(32'h810, w);
		roll_back(0, 32'h800);
		follow_strand(0, 32'h800, 5);
		finish_test();
	endtask

	task automatic test_back_pressure();
		pc_t fetch_pcs [NUM_STRANDS];
		pc_t fetch_pc;
		logic all_valid;
		start_test("back_pressure");
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			fetch_pcs[s] = 32'h1000 + 32'(s) * 32'h110;
			for (int i = 0; i < 6; i++)
				store_word(fetch_pcs[s] + 32'(4 * i), filler_word());
		end
		@(negedge clk);
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			rollback[s] = 1'b1;
			rollback_pc[s] = fetch_pcs[s];
		end
		@(negedge clk);
		for (int s = 0; s < NUM_STRANDS; s++)
			rollback[s] = 1'b0;
		// Requests stay low, so every queue fills and stalls its strand
		all_valid = 1'b0;
		while (!all_valid)
		begin
			@(negedge clk);
			all_valid = 1'b1;
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				if (instruction_valid[s] !== 1'b1)
					all_valid = 1'b0;
			end
		end
		repeat (FILL_PAUSE) @(negedge clk);
		for (int i = 0; i < 6; i++)
		begin
			for (int s = 0; s < NUM_STRANDS; s++)
			begin
				fetch_pc = fetch_pcs[s];
				expect_next(s, fetch_pc);
				fetch_pcs[s] = fetch_pc;
			end
		end
		finish_test();
	endtask

	task automatic test_rollback();
		pc_t fetch_pc;
		start_test("rollback");
		for (int i = 0; i < 8; i++)
			store_word(32'h2000 + 32'(4 * i), filler_word());
		for (int i = 0; i < 4; i++)
			store_word(32'h2100 + 32'(4 * i), filler_word());
		roll_back(0, 32'h2000);
		fetch_pc = 32'h2000;
		expect_next(0, fetch_pc);
		wait_valid(0);
		roll_back(0, 32'h2100);
		follow_strand(0, 32'h2100, 4);
		finish_test();
	endtask

	// Three words and a branch back to the start
	task automatic test_cache_reuse();
		int reads_before;
		start_test("cache_reuse");
		for (int i = 0; i < 3; i++)
			store_word(32'h3000 + 32'(4 * i), filler_word());
		store_word(32'h300C, branch_word(3'b011, -32'd16));
		roll_back(0, 32'h3000);
		follow_strand(0, 32'h3000, 8);
		@(negedge clk);
		while (mem_read !== 1'b0)
			@(negedge clk);
		reads_before = mem_reads;
		roll_back(0, 32'h3000);
		follow_strand(0, 32'h3000, 8);
		check_count("memory reads", reads_before, mem_reads);
		finish_test();
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		mem_valid = 1'b0;
		mem_data = '0;
		for (int s = 0; s < NUM_STRANDS; s++)
		begin
			instruction_req[s] = 1'b0;
			rollback[s] = 1'b0;
			rollback_pc[s] = '0;
		end
		lcg_state = 81;
		mem_reads = 0;
		error_count = 0;
		errors_before = 0;
		tests_run = 0;
		failed_tests = 0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		test_sequential_fetch();
		test_branch_prediction();
		test_long_latency();
		test_back_pressure();
		test_rollback();
		test_cache_reuse();

		$display("Summary: %0d tests, %0d with mismatches, %0d mismatches in total",
			tests_run, failed_tests, error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- build.f
+incdir+include
verilog/fetch_pkg.sv
verilog/lru_arbiter.sv
verilog/sync_fifo.sv
verilog/fetch_predecoder.sv
verilog/instruction_cache.sv
verilog/instruction_fetch_stage.sv
verilog/fetch_unit_top.sv
tests/fetch_unit_asserts.sv
tests/fetch_unit_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile the fetch unit testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert -j 0 \
	-f build.f \
	--top-module fetch_unit_tb \
	--Mdir "$BUILD_DIR" \
	-o fetch_unit_sim

"./$BUILD_DIR/fetch_unit_sim" | tee "$LOG_FILE"

if grep -q "^ALL CHECKS PASSED$" "$LOG_FILE"; then
	echo "Simulation passed"
else
	echo "Simulation failed, see $LOG_FILE"
	exit 1
fi
